/* builder/fix_tx_builder.sv */
/*
	FIX outbound message builder
	serializes the fixed 29 byte layout BeginString, MsgType,
	MsgSeqNum and CheckSum with a BCD sequence counter and a
	running byte sum, one byte per accepted handshake
*/

`timescale 1ns/1ns

module fix_tx_builder (
	input  logic             clk,
	input  logic             arst_n_i,
	input  logic             req_valid_i,
	input  fix_pkg::tx_req_t req_i,
	output logic             req_ready_o,
	output logic             tx_valid_o,
	output logic [7:0]       tx_byte_o,
	input  logic             tx_ready_i,
	output logic             done_o
);

	localparam logic [4:0] LAST_IDX = 5'(fix_pkg::MSG_LEN - 1);
	localparam logic [4:0] SUM_END  = 5'(fix_pkg::MSG_LEN - 7);	// first byte of "10="

	logic              busy;
	logic [4:0]        idx;
	fix_pkg::fix_msg_e msg_type;
	logic [3:0]        seq_h;
	logic [3:0]        seq_t;
	logic [3:0]        seq_o;
	logic [7:0]        sum;
	logic [7:0]        cs_h;
	logic [7:0]        cs_t;
	logic [7:0]        cs_o;
	logic              req_xfer;
	logic              byte_xfer;
	logic              last_byte;

	assign req_ready_o = !busy;
	assign req_xfer    = req_valid_i && !busy;
	assign tx_valid_o  = busy;
	assign byte_xfer   = busy && tx_ready_i;
	assign last_byte   = (idx == LAST_IDX);

	// checksum digits, sum is settled before they are sent
	assign cs_h = sum / 8'd100;
	assign cs_t = (sum / 8'd10) % 8'd10;
	assign cs_o = sum % 8'd10;

	always_comb begin
		case (idx)
			5'd0:  tx_byte_o = "8";
			5'd1:  tx_byte_o = "=";
			5'd2:  tx_byte_o = "F";
			5'd3:  tx_byte_o = "I";
			5'd4:  tx_byte_o = "X";
			5'd5:  tx_byte_o = ".";
			5'd6:  tx_byte_o = "4";
			5'd7:  tx_byte_o = ".";
			5'd8:  tx_byte_o = "2";
			5'd10: tx_byte_o = "3";
			5'd11: tx_byte_o = "5";
			5'd12: tx_byte_o = "=";
			5'd13: tx_byte_o = msg_type;		// latched type char
			5'd15: tx_byte_o = "3";
			5'd16: tx_byte_o = "4";
			5'd17: tx_byte_o = "=";
			5'd18: tx_byte_o = {4'h3, seq_h};
			5'd19: tx_byte_o = {4'h3, seq_t};
			5'd20: tx_byte_o = {4'h3, seq_o};
			5'd22: tx_byte_o = "1";
			5'd23: tx_byte_o = "0";
			5'd24: tx_byte_o = "=";
			5'd25: tx_byte_o = "0" + cs_h;
			5'd26: tx_byte_o = "0" + cs_t;
			5'd27: tx_byte_o = "0" + cs_o;
			default: tx_byte_o = fix_pkg::SOH;	// 9, 14, 21 and 28
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			busy   <= 1'b0;
			idx    <= '0;
			done_o <= 1'b0;
			seq_h  <= 4'd0;
			seq_t  <= 4'd0;
			seq_o  <= 4'd1;			// first message is 001
		end else begin
			done_o <= byte_xfer && last_byte;
			if (req_xfer) begin
				busy <= 1'b1;
				idx  <= '0;
			end else if (byte_xfer) begin
				if (last_byte)
					busy <= 1'b0;
				else
					idx <= idx + 1'b1;
			end
			if (byte_xfer && last_byte) begin	// bcd step, 999 wraps to 000
				if (seq_o != 4'd9) begin
					seq_o <= seq_o + 1'b1;
				end else begin
					seq_o <= 4'd0;
					if (seq_t != 4'd9) begin
						seq_t <= seq_t + 1'b1;
					end else begin
						seq_t <= 4'd0;
						seq_h <= (seq_h == 4'd9) ? 4'd0 : seq_h + 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req_xfer)
			msg_type <= req_i.msg_type;
		if (req_xfer)
			sum <= '0;
		else if (byte_xfer && idx < SUM_END)
			sum <= sum + tx_byte_o;		// mod 256 by width
	end

endmodule

/* common/fix_pkg.sv */
/*
	FIX session engine shared definitions
	message and session state encodings, the parser result and
	builder request structs, and the protocol constants used by
	the inbound parser, the session FSM, the heartbeat timer and
	the outbound builder
*/

package fix_pkg;

	// MsgType values carry their own ASCII character
	typedef enum logic [7:0] {
		LOGON     = 8'h41,			// 'A'
		HEARTBEAT = 8'h30,			// '0'
		TEST_REQ  = 8'h31,			// '1'
		LOGOUT    = 8'h35,			// '5'
		OTHER     = 8'h3f			// any other type character
	} fix_msg_e;

	typedef enum logic [1:0] {
		IDLE        = 2'd0,
		LOGON_SENT  = 2'd1,			// waiting for the peer logon
		ACTIVE      = 2'd2,
		LOGOUT_SENT = 2'd3			// waiting for the peer logout
	} session_state_e;

	// parser result, qualified by a separate one cycle valid
	typedef struct packed {
		fix_msg_e msg_type;
		logic     checksum_ok;
	} rx_msg_t;

	// session FSM to builder request
	typedef struct packed {
		fix_msg_e msg_type;
	} tx_req_t;

	localparam logic [7:0] SOH = 8'h01;	// field delimiter

	localparam int MSG_LEN = 29;		// bytes in every outbound message

	localparam int TAG_MSGTYPE = 35;
	localparam int TAG_CHECKSUM = 10;

	localparam int HB_WIDTH = 16;		// heartbeat down-counter width

endpackage

/* parser/fix_rx_parser.sv */
/*
	FIX inbound parser
	splits tag=value fields at SOH, captures the MsgType character
	and checks the received CheckSum against the byte sum of the
	message up to the tag 10 field
*/

`timescale 1ns/1ns

module fix_rx_parser (
	input  logic             clk,
	input  logic             arst_n_i,
	input  logic             rx_valid_i,
	input  logic [7:0]       rx_byte_i,
	output logic             rx_msg_valid_o,
	output fix_pkg::rx_msg_t rx_msg_o,
	output logic             rx_error_o
);

	logic              in_value;		// value part of a field, else tag part
	logic [13:0]       tag_num;
	logic              type_field;		// first char of tag 35 value expected
	logic              cs_field;		// inside the tag 10 value
	logic [7:0]        sum;
	logic [7:0]        frozen_sum;
	logic [9:0]        cs_val;
	fix_pkg::fix_msg_e msg_type;

	logic              tag_eq;			// '=' ends the tag
	logic              val_soh;			// SOH ends the value
	logic              val_char;
	logic              cs_match;

	assign tag_eq   = rx_valid_i && !in_value && (rx_byte_i == "=");
	assign val_soh  = rx_valid_i && in_value && (rx_byte_i == fix_pkg::SOH);
	assign val_char = rx_valid_i && in_value && (rx_byte_i != fix_pkg::SOH);
	assign cs_match = (cs_val == {2'b00, frozen_sum});

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			in_value       <= 1'b0;
			tag_num        <= '0;
			type_field     <= 1'b0;
			cs_field       <= 1'b0;
			sum            <= '0;
			rx_msg_valid_o <= 1'b0;
			rx_error_o     <= 1'b0;
		end else begin
			rx_msg_valid_o <= 1'b0;
			rx_error_o     <= 1'b0;
			if (rx_valid_i)
				sum <= sum + rx_byte_i;
			if (tag_eq) begin
				in_value   <= 1'b1;
				type_field <= (tag_num == 14'(fix_pkg::TAG_MSGTYPE));
				cs_field   <= (tag_num == 14'(fix_pkg::TAG_CHECKSUM));
			end else if (rx_valid_i && !in_value) begin
				tag_num <= tag_num * 14'd10 + {10'd0, rx_byte_i[3:0]};	// ascii digit
			end
			if (val_char)
				type_field <= 1'b0;
			if (val_soh) begin
				in_value   <= 1'b0;
				tag_num    <= '0;
				type_field <= 1'b0;
				cs_field   <= 1'b0;
				if (cs_field) begin			// end of message
					sum            <= '0;
					rx_msg_valid_o <= 1'b1;
					rx_error_o     <= !cs_match;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (val_soh && !cs_field)
			frozen_sum <= sum + rx_byte_i;	// sum through this SOH, kept once tag 10 starts
		if (tag_eq)
			cs_val <= '0;
		else if (val_char && cs_field)
			cs_val <= cs_val * 10'd10 + {6'd0, rx_byte_i[3:0]};
		if (val_char && type_field) begin
			case (rx_byte_i)
				fix_pkg::LOGON, fix_pkg::HEARTBEAT, fix_pkg::TEST_REQ, fix_pkg::LOGOUT:
					msg_type <= fix_pkg::fix_msg_e'(rx_byte_i);
				default:
					msg_type <= fix_pkg::OTHER;
			endcase
		end
		if (val_soh && cs_field) begin
			rx_msg_o.msg_type    <= msg_type;
			rx_msg_o.checksum_ok <= cs_match;
		end
	end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fix_engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_fix_engine -f verilog.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_fix_engine)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# pass only if the testbench printed its pass line
if echo "$output" | grep -qxF "test passed"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1

/* sim/fix_engine_asserts.sv */
/*
	FIX engine assertions
	outbound handshake hold and reset state, bound to the top level
*/

`timescale 1ns/1ns

module fix_engine_asserts (
	input logic       clk,
	input logic       arst_n_i,
	input logic       tx_valid_o,
	input logic       tx_ready_i,
	input logic [7:0] tx_byte_o,
	input logic       session_active_o
);

	// a stalled byte stays on the bus until taken
	property tx_hold_p;
		@(posedge clk) disable iff (!arst_n_i)
		(tx_valid_o && !tx_ready_i) |=> (tx_valid_o && $stable(tx_byte_o));
	endproperty

	property reset_quiet_p;
		@(posedge clk) !arst_n_i |-> (!tx_valid_o && !session_active_o);
	endproperty

	assert property (tx_hold_p) else $error("tx_byte_o or tx_valid_o changed while stalled");
	assert property (reset_quiet_p) else $error("tx_valid_o or session_active_o high in reset");

endmodule

bind fix_engine fix_engine_asserts u_fix_engine_asserts (
	.clk              (clk),
	.arst_n_i         (arst_n_i),
	.tx_valid_o       (tx_valid_o),
	.tx_ready_i       (tx_ready_i),
	.tx_byte_o        (tx_byte_o),
	.session_active_o (session_active_o)
);

/* sim/tb_fix_engine.sv */
/*
	FIX session engine testbench
	directed tests for logon, test request, idle heartbeat, corrupt
	checksum, back-pressure and peer logout over the byte streams
*/

`timescale 1ns/1ns

module tb_fix_engine;

	localparam int HB_INTERVAL = 300;
	localparam int MAX_CYCLES  = 20000;		// two idle heartbeat waits plus traffic, wide margin

	logic       clk;
	logic       arst_n_i;
	logic       connect_i;
	logic       disconnect_i;
	logic       rx_valid_i;
	logic [7:0] rx_byte_i;
	logic       tx_ready_i;
	logic       tx_valid_o;
	logic [7:0] tx_byte_o;
	logic       session_active_o;
	logic       rx_error_o;

	logic [7:0]  frame[$];					// last message built by the testbench
	logic [7:0]  rx_buf[fix_pkg::MSG_LEN];	// message collected from the DUT
	logic [31:0] lcg_state;
	int          errors;
	int          failed_tests;
	int          peer_seq;
	int          cycle_count = 0;
	int          rx_error_count = 0;

	fix_engine #(
		.HB_INTERVAL (HB_INTERVAL)
	) u_fix_engine (
		.clk              (clk),
		.arst_n_i         (arst_n_i),
		.connect_i        (connect_i),
		.disconnect_i     (disconnect_i),
		.rx_valid_i       (rx_valid_i),
		.rx_byte_i        (rx_byte_i),
		.tx_ready_i       (tx_ready_i),
		.tx_valid_o       (tx_valid_o),
		.tx_byte_o        (tx_byte_o),
		.session_active_o (session_active_o),
		.rx_error_o       (rx_error_o)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: tests did not finish within %0d cycles", cycle_count);
			$display("test failed");
			$finish;
		end
	end

	always @(negedge clk) begin
		if (rx_error_o)
			rx_error_count++;			// registered pulse, stable at negedge
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic add_field(input string s);
		for (int i = 0; i < s.len(); i++)
			frame.push_back(s[i]);
		frame.push_back(fix_pkg::SOH);
	endtask

	// fixed layout used in both directions
	task automatic build_frame(input logic [7:0] type_char, input int seq, input bit corrupt);
		int sum;
		sum = 0;
		frame.delete();
		add_field("8=FIX.4.2");
		add_field($sformatf("35=%c", type_char));
		add_field($sformatf("34=%03d", seq % 1000));
		foreach (frame[i])
			sum = sum + int'(frame[i]);
		if (corrupt)
			sum = sum + 1;				// off by one, never matches
		add_field($sformatf("10=%03d", sum % 256));
	endtask

	task automatic compare_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("error %s: got 0x%h expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_type(input string name, input fix_pkg::fix_msg_e got,
			input fix_pkg::fix_msg_e exp);
		if (got !== exp) begin
			$display("error %s: got 0x%h expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error %s: got 0x%h expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic send_msg(input fix_pkg::fix_msg_e msg_type, input bit corrupt);
		build_frame(msg_type, peer_seq, corrupt);
		peer_seq++;
		foreach (frame[i]) begin
			@(negedge clk);
			rx_valid_i = 1'b1;
			rx_byte_i  = frame[i];
		end
		@(negedge clk);
		rx_valid_i = 1'b0;
	endtask

	function automatic int digits_at(input int at);
		return (int'(rx_buf[at]) - 48) * 100 + (int'(rx_buf[at + 1]) - 48) * 10
			+ int'(rx_buf[at + 2]) - 48;
	endfunction

	task automatic recv_msg(input int max_wait, input bit random_ready,
			output fix_pkg::fix_msg_e got_type, output int got_seq, output int got_cs);
		int          n;
		int          waited;
		bit          held;
		logic [7:0]  held_byte;
		logic [31:0] r;
		n         = 0;
		waited    = 0;
		held      = 1'b0;
		held_byte = '0;
		while (n < fix_pkg::MSG_LEN && !(n == 0 && waited >= max_wait)) begin
			@(negedge clk);
			if (random_ready) begin
				r          = lcg_next();
				tx_ready_i = r[16];
			end else begin
				tx_ready_i = 1'b1;
			end
			if (held) begin				// last cycle stalled
				compare_bit("tx_valid_o held", tx_valid_o, 1'b1);
				compare_byte("tx_byte_o held", tx_byte_o, held_byte);
			end
			held      = tx_valid_o && !tx_ready_i;
			held_byte = tx_byte_o;
			if (tx_valid_o && tx_ready_i) begin
				rx_buf[n] = tx_byte_o;	// moves on the next rising edge
				n++;
			end else if (n == 0) begin
				waited++;
			end
		end
		tx_ready_i = 1'b1;
		if (n < fix_pkg::MSG_LEN) begin
			$display("no complete message came from the DUT within %0d cycles", max_wait);
			errors++;
		end
		got_type = fix_pkg::fix_msg_e'(rx_buf[13]);
		got_seq  = digits_at(18);
		got_cs   = digits_at(25);
	endtask

	task automatic expect_msg(input fix_pkg::fix_msg_e exp_type, input int exp_seq,
			input int max_wait, input bit random_ready);
		fix_pkg::fix_msg_e got_type;
		int                got_seq;
		int                got_cs;
		logic [7:0]        sum;
		recv_msg(max_wait, random_ready, got_type, got_seq, got_cs);
		build_frame(exp_type, exp_seq, 1'b0);
		sum = '0;
		for (int i = 0; i < fix_pkg::MSG_LEN - 7; i++)
			sum = sum + frame[i];		// CheckSum field is the last 7 bytes
		compare_type("msg type", got_type, exp_type);
		compare_byte("msg seq", 8'(got_seq), 8'(exp_seq));
		compare_byte("checksum", 8'(got_cs), sum);
		for (int i = 0; i < fix_pkg::MSG_LEN; i++)
			compare_byte($sformatf("tx_byte_o[%0d]", i), rx_buf[i], frame[i]);
	endtask

	task automatic wait_active(input logic exp, input int limit);
		int i;
		i = 0;
		while (session_active_o !== exp && i < limit) begin
			@(negedge clk);
			i++;
		end
		compare_bit("session_active_o", session_active_o, exp);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, errors - errors_before);
			failed_tests++;
		end
	endtask

	task automatic logon_exchange();
		int e0;
		e0 = errors;
		@(negedge clk);
		connect_i = 1'b1;
		@(negedge clk);
		connect_i = 1'b0;
		expect_msg(fix_pkg::LOGON, 1, 50, 1'b0);
		send_msg(fix_pkg::LOGON, 1'b0);
		wait_active(1'b1, 10);
		finish_test("logon", e0);
	endtask

	task automatic test_request_reply();
		int e0;
		e0 = errors;
		send_msg(fix_pkg::TEST_REQ, 1'b0);
		expect_msg(fix_pkg::HEARTBEAT, 2, 50, 1'b0);
		finish_test("test request", e0);
	endtask

	task automatic idle_heartbeat();
		int e0;
		e0 = errors;
		expect_msg(fix_pkg::HEARTBEAT, 3, 2 * HB_INTERVAL, 1'b0);
		finish_test("idle heartbeat", e0);
	endtask

	task automatic corrupt_checksum();
		int e0;
		int seen_before;
		int busy_cycles;
		e0          = errors;
		seen_before = rx_error_count;
		busy_cycles = 0;
		send_msg(fix_pkg::LOGOUT, 1'b1);
		repeat (20) begin
			@(negedge clk);
			if (tx_valid_o)
				busy_cycles++;
		end
		if (busy_cycles != 0) begin
			$display("the DUT sent a message after a logout with a bad checksum");
			errors++;
		end
		compare_bit("rx_error_o pulse", rx_error_count == seen_before + 1, 1'b1);
		compare_bit("session_active_o", session_active_o, 1'b1);
		finish_test("corrupt checksum", e0);
	endtask

	task automatic backpressure_reply();
		int e0;
		e0 = errors;
		send_msg(fix_pkg::TEST_REQ, 1'b0);
		expect_msg(fix_pkg::HEARTBEAT, 4, 50, 1'b1);
		finish_test("back-pressure", e0);
	endtask

	task automatic peer_logout();
		int e0;
		e0 = errors;
		send_msg(fix_pkg::LOGOUT, 1'b0);
		expect_msg(fix_pkg::LOGOUT, 5, 50, 1'b0);
		compare_bit("session_active_o", session_active_o, 1'b0);
		finish_test("peer logout", e0);
	endtask

	initial begin
		clk          = 1'b0;
		arst_n_i     = 1'b0;
		connect_i    = 1'b0;
		disconnect_i = 1'b0;
		rx_valid_i   = 1'b0;
		rx_byte_i    = '0;
		tx_ready_i   = 1'b1;
		lcg_state    = 32'd35;
		errors       = 0;
		failed_tests = 0;
		peer_seq     = 1;
		repeat (3) @(negedge clk);
		compare_bit("tx_valid_o in reset", tx_valid_o, 1'b0);
		compare_bit("session_active_o in reset", session_active_o, 1'b0);
		finish_test("reset", 0);
		arst_n_i = 1'b1;
		logon_exchange();
		test_request_reply();
		idle_heartbeat();
		corrupt_checksum();
		backpressure_reply();
		peer_logout();
		$display("tests run: 7, failing tests: %0d, errors: %0d", failed_tests, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* source/fix_engine.sv */
/*
	FIX session engine top level
	one session over a byte stream: inbound parser, session FSM,
	heartbeat timer and outbound message builder
*/

`timescale 1ns/1ns

module fix_engine #(
	parameter int HB_INTERVAL = 300
) (
	input  logic       clk,
	input  logic       arst_n_i,
	input  logic       connect_i,			// from app
	input  logic       disconnect_i,		// from app
	input  logic       rx_valid_i,			// inbound stream, one byte per cycle
	input  logic [7:0] rx_byte_i,
	input  logic       tx_ready_i,			// outbound stream
	output logic       tx_valid_o,
	output logic [7:0] tx_byte_o,
	output logic       session_active_o,
	output logic       rx_error_o
);

	logic              rx_msg_valid;
	fix_pkg::rx_msg_t  rx_msg;
	logic              tx_req_valid;
	fix_pkg::tx_req_t  tx_req;
	logic              tx_req_ready;
	logic              tx_done;
	logic              timer_run;
	logic              hb_due;

	fix_rx_parser u_fix_rx_parser (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.rx_valid_i     (rx_valid_i),
		.rx_byte_i      (rx_byte_i),
		.rx_msg_valid_o (rx_msg_valid),		// to session FSM
		.rx_msg_o       (rx_msg),
		.rx_error_o     (rx_error_o)
	);

	session_fsm u_session_fsm (
		.clk              (clk),
		.arst_n_i         (arst_n_i),
		.connect_i        (connect_i),
		.disconnect_i     (disconnect_i),
		.rx_msg_valid_i   (rx_msg_valid),
		.rx_msg_i         (rx_msg),
		.hb_due_i         (hb_due),
		.tx_req_valid_o   (tx_req_valid),	// to builder
		.tx_req_o         (tx_req),
		.tx_req_ready_i   (tx_req_ready),
		.timer_run_o      (timer_run),
		.session_active_o (session_active_o)
	);

	heartbeat_timer #(
		.HB_INTERVAL (HB_INTERVAL)
	) u_heartbeat_timer (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.run_i     (timer_run),
		.restart_i (tx_done),			// every sent message restarts it
		.due_o     (hb_due)
	);

	fix_tx_builder u_fix_tx_builder (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.req_valid_i (tx_req_valid),
		.req_i       (tx_req),
		.req_ready_o (tx_req_ready),
		.tx_valid_o  (tx_valid_o),
		.tx_byte_o   (tx_byte_o),
		.tx_ready_i  (tx_ready_i),
		.done_o      (tx_done)
	);

endmodule

/* source/heartbeat_timer.sv */
/*
	Heartbeat timer
	down-counter that pulses when no message has been sent for
	HB_INTERVAL cycles while the session is active
*/

`timescale 1ns/1ns

module heartbeat_timer #(
	parameter int HB_INTERVAL = 300
) (
	input  logic clk,
	input  logic arst_n_i,
	input  logic run_i,				// session active
	input  logic restart_i,			// message sent
	output logic due_o
);

	localparam logic [fix_pkg::HB_WIDTH-1:0] RELOAD = fix_pkg::HB_WIDTH'(HB_INTERVAL);

	logic [fix_pkg::HB_WIDTH-1:0] count;
	logic                         run_q;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			count <= '0;
			run_q <= 1'b0;
			due_o <= 1'b0;
		end else begin
			run_q <= run_i;
			due_o <= 1'b0;
			if (!run_i) begin
				count <= '0;
			end else if (!run_q || restart_i) begin
				count <= RELOAD;			// session just went active or message sent
			end else if (count == 1) begin
				due_o <= 1'b1;
				count <= RELOAD;
			end else begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

/* source/session_fsm.sv */
/*
	FIX session state machine
	handles logon, test request, heartbeat and logout for one
	counterparty and issues one message request at a time to the
	outbound builder
*/

`timescale 1ns/1ns

module session_fsm (
	input  logic             clk,
	input  logic             arst_n_i,
	input  logic             connect_i,
	input  logic             disconnect_i,
	input  logic             rx_msg_valid_i,
	input  fix_pkg::rx_msg_t rx_msg_i,
	input  logic             hb_due_i,
	output logic             tx_req_valid_o,
	output fix_pkg::tx_req_t tx_req_o,
	input  logic             tx_req_ready_i,
	output logic             timer_run_o,
	output logic             session_active_o
);

	fix_pkg::session_state_e state;
	fix_pkg::session_state_e state_nxt;

	logic              rx_good;			// message with a valid checksum
	logic              hold_valid;
	fix_pkg::fix_msg_e hold_type;		// message parked behind a pending request
	logic              msg_valid;
	fix_pkg::fix_msg_e msg_type;
	logic              req_fire;
	fix_pkg::fix_msg_e req_type;

	assign rx_good   = rx_msg_valid_i && rx_msg_i.checksum_ok;
	assign msg_valid = hold_valid || rx_good;
	assign msg_type  = hold_valid ? hold_type : rx_msg_i.msg_type;	// oldest first

	assign session_active_o = (state == fix_pkg::ACTIVE);
	assign timer_run_o      = (state == fix_pkg::ACTIVE);

	// events are only acted on once the previous request has moved
	always_comb begin
		state_nxt = state;
		req_fire  = 1'b0;
		req_type  = fix_pkg::HEARTBEAT;
		if (!tx_req_valid_o) begin
			case (state)
				fix_pkg::IDLE: begin
					if (connect_i) begin
						req_fire  = 1'b1;
						req_type  = fix_pkg::LOGON;
						state_nxt = fix_pkg::LOGON_SENT;
					end
				end
				fix_pkg::LOGON_SENT: begin
					if (msg_valid && msg_type == fix_pkg::LOGON)
						state_nxt = fix_pkg::ACTIVE;
				end
				fix_pkg::ACTIVE: begin
					if (msg_valid && msg_type == fix_pkg::LOGOUT) begin
						req_fire  = 1'b1;		// answer the peer logout
						req_type  = fix_pkg::LOGOUT;
						state_nxt = fix_pkg::IDLE;
					end else if (disconnect_i) begin
						req_fire  = 1'b1;
						req_type  = fix_pkg::LOGOUT;
						state_nxt = fix_pkg::LOGOUT_SENT;
					end else if (hb_due_i || (msg_valid && msg_type == fix_pkg::TEST_REQ)) begin
						req_fire  = 1'b1;
						req_type  = fix_pkg::HEARTBEAT;
					end
				end
				fix_pkg::LOGOUT_SENT: begin
					if (msg_valid && msg_type == fix_pkg::LOGOUT)
						state_nxt = fix_pkg::IDLE;
				end
				default: state_nxt = fix_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state          <= fix_pkg::IDLE;
			tx_req_valid_o <= 1'b0;
			hold_valid     <= 1'b0;
		end else begin
			state <= state_nxt;
			if (req_fire)
				tx_req_valid_o <= 1'b1;
			else if (tx_req_ready_i)
				tx_req_valid_o <= 1'b0;		// transfer done
			if (tx_req_valid_o)
				hold_valid <= hold_valid || rx_good;
			else
				hold_valid <= hold_valid && rx_good;	// held one consumed, park the new one
		end
	end

	always_ff @(posedge clk) begin
		if (req_fire)
			tx_req_o.msg_type <= req_type;
		if (rx_good && (tx_req_valid_o || hold_valid))
			hold_type <= rx_msg_i.msg_type;
	end

endmodule

/* verilog.f */
common/fix_pkg.sv
parser/fix_rx_parser.sv
builder/fix_tx_builder.sv
source/heartbeat_timer.sv
source/session_fsm.sv
source/fix_engine.sv
sim/fix_engine_asserts.sv
sim/tb_fix_engine.sv
